//--- rtl/hdr_defs.svh
`ifndef HDR_DEFS_SVH
`define HDR_DEFS_SVH

// payload bits carried by one HDR-DDR word
`define HDR_PAYLOAD_W 16

// payload plus the trailing even-parity bit
`define HDR_FRAME_W 17

// target register file written by normal transactions
`define HDR_REG_DEPTH 8
`define HDR_REG_AW 3

// dynamic address of the target
`define HDR_ADDR_W 7
`define HDR_DEFAULT_ADDR 7'h2a

`endif

//--- rtl/hdr_pkg.sv
`default_nettype none

package hdr_pkg;

	typedef enum logic [2:0] {
		IDLE_SDR    = 3'd0, // waiting for ENTHDR on the SDR side
		IDLE_HDR    = 3'd1,
		INITIALIZE  = 3'd2, // receiving the command word
		CCC_HANDLER = 3'd3,
		DDR_NT      = 3'd4
	} engine_state_e;

	typedef enum logic [1:0] {
		NOT_ME = 2'd0,
		ME_DDR = 2'd1,
		CCC    = 2'd2,
		ERROR  = 2'd3 // command word failed parity
	} rx_decision_e;

	typedef enum logic {
		RX_CMD  = 1'b0,
		RX_DATA = 1'b1
	} rx_mode_e;

	typedef enum logic [7:0] {
		CCC_RSTADDR = 8'h01,
		CCC_SETADDR = 8'h02
	} ccc_opcode_e;

endpackage

`default_nettype wire

//--- rtl/hdr_engine.sv
`timescale 1ns/100ps
`default_nettype none

module hdr_engine (
	input  wire                        i_sys_clk,
	input  wire                        i_sys_rst,
	input  wire                        i_enthdr,
	input  wire                        i_exit,
	input  wire                        i_restart,
	input  wire                        i_decision_stb,
	input  wire hdr_pkg::rx_decision_e i_decision,
	input  wire                        i_nt_done,
	input  wire                        i_ccc_done,
	output logic                       o_enthdr_en,
	output logic                       o_rx_en,
	output hdr_pkg::rx_mode_e          o_rx_mode,
	output logic                       o_nt_en,
	output logic                       o_ccc_en
);

	hdr_pkg::engine_state_e current_state;
	hdr_pkg::engine_state_e next_state;

	always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
		if (!i_sys_rst) begin
			current_state <= hdr_pkg::IDLE_SDR;
		end else begin
			current_state <= next_state;
		end
	end

	// outputs and next state both come straight from the current state
	always_comb begin
		o_enthdr_en = 1'b0;
		o_rx_en     = 1'b0;
		o_rx_mode   = hdr_pkg::RX_DATA; // only the command word is decoded
		o_nt_en     = 1'b0;
		o_ccc_en    = 1'b0;
		next_state  = current_state;
		case (current_state)
			hdr_pkg::IDLE_SDR: begin
				o_enthdr_en = 1'b1; // lets the SDR side look for ENTHDR
				if (i_enthdr) begin
					next_state = hdr_pkg::INITIALIZE;
				end
			end
			hdr_pkg::IDLE_HDR: begin
				if (i_exit) begin
					next_state = hdr_pkg::IDLE_SDR; // exit wins over restart
				end else if (i_restart) begin
					next_state = hdr_pkg::INITIALIZE;
				end
			end
			hdr_pkg::INITIALIZE: begin
				o_rx_en   = 1'b1;
				o_rx_mode = hdr_pkg::RX_CMD;
				if (i_decision_stb) begin
					case (i_decision)
						hdr_pkg::ME_DDR: next_state = hdr_pkg::DDR_NT;
						hdr_pkg::CCC:    next_state = hdr_pkg::CCC_HANDLER;
						default:         next_state = hdr_pkg::IDLE_HDR; // not addressed or bad parity
					endcase
				end
			end
			hdr_pkg::DDR_NT: begin
				o_rx_en = 1'b1; // data words keep flowing into the deserializer
				o_nt_en = 1'b1;
				if (i_nt_done) begin
					next_state = hdr_pkg::IDLE_HDR;
				end
			end
			hdr_pkg::CCC_HANDLER: begin
				o_rx_en  = 1'b1;
				o_ccc_en = 1'b1;
				if (i_ccc_done) begin
					next_state = hdr_pkg::IDLE_HDR;
				end
			end
			default: begin
				next_state = hdr_pkg::IDLE_SDR; // unused encodings recover to SDR
			end
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/hdr_bit_counter.sv
`timescale 1ns/100ps
`default_nettype none

`include "hdr_defs.svh"

module hdr_bit_counter (
	input  wire  i_sys_clk,
	input  wire  i_sys_rst,
	input  wire  i_rx_en,
	input  wire  i_bit_stb,
	output logic o_shift_stb,
	output logic o_last_bit
);

	localparam int CNT_W = $clog2(`HDR_FRAME_W);

	logic [CNT_W-1:0] bit_cnt;

	assign o_shift_stb = i_rx_en & i_bit_stb; // bits outside a receive window are dropped
	assign o_last_bit  = (bit_cnt == CNT_W'(`HDR_FRAME_W - 1)); // the parity bit is next

	always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
		if (!i_sys_rst) begin
			bit_cnt <= '0;
		end else if (!i_rx_en) begin
			bit_cnt <= '0; // every receive window starts on a word boundary
		end else if (o_shift_stb) begin
			if (o_last_bit) begin
				bit_cnt <= '0;
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/hdr_rx_deser.sv
`timescale 1ns/100ps
`default_nettype none

`include "hdr_defs.svh"

module hdr_rx_deser (
	input  wire                        i_sys_clk,
	input  wire                        i_sys_rst,
	input  wire                        i_shift_stb,
	input  wire                        i_last_bit,
	input  wire                        i_bit,
	input  wire hdr_pkg::rx_mode_e     i_rx_mode,
	input  wire [`HDR_ADDR_W-1:0]      i_own_addr,
	output logic                       o_word_stb,
	output logic [`HDR_PAYLOAD_W-1:0]  o_word,
	output logic                       o_parity_err,
	output logic [7:0]                 o_cmd_arg,
	output logic                       o_decision_stb,
	output hdr_pkg::rx_decision_e      o_decision
);

	logic [`HDR_PAYLOAD_W-1:0] shift_reg;
	logic                      word_end;
	logic                      cmd_mode;
	logic                      frame_odd;
	logic                      cmd_ccc;
	logic [`HDR_ADDR_W-1:0]    cmd_addr;

	assign word_end  = i_shift_stb & i_last_bit; // i_bit is the parity bit here
	assign cmd_mode  = (i_rx_mode == hdr_pkg::RX_CMD);
	assign frame_odd = ^{shift_reg, i_bit}; // even parity means zero over all 17 bits
	assign cmd_ccc   = shift_reg[`HDR_PAYLOAD_W-1];
	assign cmd_addr  = shift_reg[`HDR_PAYLOAD_W-2 -: `HDR_ADDR_W];

	always_ff @(posedge i_sys_clk) begin
		if (word_end) begin
			o_word <= shift_reg;
			if (cmd_mode) begin
				o_cmd_arg <= shift_reg[7:0]; // opcode or word count minus one
			end
		end else if (i_shift_stb) begin
			shift_reg <= {shift_reg[`HDR_PAYLOAD_W-2:0], i_bit}; // MSB arrives first
		end
	end

	always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
		if (!i_sys_rst) begin
			o_word_stb     <= 1'b0;
			o_decision_stb <= 1'b0;
			o_parity_err   <= 1'b0;
			o_decision     <= hdr_pkg::NOT_ME;
		end else begin
			o_word_stb     <= word_end;
			o_decision_stb <= word_end & cmd_mode;
			if (word_end) begin
				o_parity_err <= frame_odd;
			end
			if (word_end && cmd_mode) begin
				if (frame_odd) begin
					o_decision <= hdr_pkg::ERROR;
				end else if (cmd_ccc) begin
					o_decision <= hdr_pkg::CCC; // broadcast, address field ignored
				end else if (cmd_addr == i_own_addr) begin
					o_decision <= hdr_pkg::ME_DDR;
				end else begin
					o_decision <= hdr_pkg::NOT_ME;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/hdr_nt_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "hdr_defs.svh"

module hdr_nt_unit (
	input  wire                        i_sys_clk,
	input  wire                        i_sys_rst,
	input  wire                        i_nt_en,
	input  wire                        i_word_stb,
	input  wire [`HDR_PAYLOAD_W-1:0]   i_word,
	input  wire                        i_parity_err,
	input  wire [7:0]                  i_cmd_arg,
	output logic                       o_wr_stb,
	output logic [`HDR_REG_AW-1:0]     o_wr_addr,
	output logic [`HDR_PAYLOAD_W-1:0]  o_wr_data,
	output logic                       o_nt_done,
	output logic                       o_bad_word
);

	logic                   nt_en_q;
	logic [`HDR_REG_AW-1:0] words_left; // data words still expected, minus one
	logic [`HDR_REG_AW-1:0] wr_idx;
	logic                   data_word;

	assign data_word = i_nt_en & i_word_stb;

	always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
		if (!i_sys_rst) begin
			nt_en_q    <= 1'b0;
			words_left <= '0;
			wr_idx     <= '0;
			o_wr_stb   <= 1'b0;
			o_nt_done  <= 1'b0;
			o_bad_word <= 1'b0;
		end else begin
			nt_en_q    <= i_nt_en;
			o_wr_stb   <= 1'b0;
			o_nt_done  <= 1'b0;
			o_bad_word <= 1'b0;
			if (i_nt_en && !nt_en_q) begin
				words_left <= i_cmd_arg[`HDR_REG_AW-1:0]; // only the low bits of the count matter
				wr_idx     <= '0;
			end else if (data_word) begin
				o_wr_stb   <= ~i_parity_err; // a corrupted word still takes its index
				o_bad_word <= i_parity_err;
				o_nt_done  <= (words_left == '0);
				words_left <= words_left - 1'b1;
				wr_idx     <= wr_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge i_sys_clk) begin
		if (data_word) begin
			o_wr_addr <= wr_idx;
			o_wr_data <= i_word;
		end
	end

endmodule

`default_nettype wire

//--- rtl/hdr_ccc_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "hdr_defs.svh"

module hdr_ccc_unit (
	input  wire                       i_sys_clk,
	input  wire                       i_sys_rst,
	input  wire                       i_ccc_en,
	input  wire                       i_word_stb,
	input  wire [`HDR_PAYLOAD_W-1:0]  i_word,
	input  wire                       i_parity_err,
	input  wire [7:0]                 i_cmd_arg,
	output logic [`HDR_ADDR_W-1:0]    o_own_addr,
	output logic                      o_ccc_done
);

	hdr_pkg::ccc_opcode_e opcode;
	logic                 ccc_en_q;
	logic                 ccc_first;
	logic                 addr_wait; // set-address is waiting for its data word
	logic                 word_done;

	assign opcode    = hdr_pkg::ccc_opcode_e'(i_cmd_arg);
	assign ccc_first = i_ccc_en & ~ccc_en_q;

	// single-word CCCs finish in the very first enabled cycle
	assign o_ccc_done = (ccc_first & (opcode != hdr_pkg::CCC_SETADDR)) | word_done;

	always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
		if (!i_sys_rst) begin
			ccc_en_q   <= 1'b0;
			addr_wait  <= 1'b0;
			word_done  <= 1'b0;
			o_own_addr <= `HDR_DEFAULT_ADDR;
		end else begin
			ccc_en_q  <= i_ccc_en;
			word_done <= 1'b0;
			if (!i_ccc_en) begin
				addr_wait <= 1'b0;
			end else if (ccc_first) begin
				case (opcode)
					hdr_pkg::CCC_SETADDR: addr_wait  <= 1'b1;
					hdr_pkg::CCC_RSTADDR: o_own_addr <= `HDR_DEFAULT_ADDR;
					default:              addr_wait  <= 1'b0; // unknown opcodes are ignored
				endcase
			end else if (addr_wait && i_word_stb) begin
				addr_wait <= 1'b0;
				word_done <= 1'b1;
				if (!i_parity_err) begin
					o_own_addr <= i_word[`HDR_ADDR_W-1:0]; // a bad word keeps the old address
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/hdr_target_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "hdr_defs.svh"

module hdr_target_top (
	input  wire                       i_sys_clk,
	input  wire                       i_sys_rst,
	input  wire                       i_enthdr,
	input  wire                       i_exit,
	input  wire                       i_restart,
	input  wire                       i_bit_stb,
	input  wire                       i_bit,
	output logic                      o_enthdr_en,
	output logic                      o_wr_stb,
	output logic [`HDR_REG_AW-1:0]    o_wr_addr,
	output logic [`HDR_PAYLOAD_W-1:0] o_wr_data,
	output logic                      o_parity_err,
	output logic [`HDR_ADDR_W-1:0]    o_own_addr
);

	logic                      rx_en;
	hdr_pkg::rx_mode_e         rx_mode;
	logic                      nt_en;
	logic                      ccc_en;
	logic                      shift_stb;
	logic                      last_bit;
	logic                      word_stb;
	logic [`HDR_PAYLOAD_W-1:0] word;
	logic                      word_par_err;
	logic [7:0]                cmd_arg;
	logic                      decision_stb;
	hdr_pkg::rx_decision_e     decision;
	logic                      nt_done;
	logic                      ccc_done;

	assign o_parity_err = word_stb & word_par_err; // one pulse per failing word

	hdr_engine engine_i (
		.i_sys_clk      (i_sys_clk),
		.i_sys_rst      (i_sys_rst),
		.i_enthdr       (i_enthdr),
		.i_exit         (i_exit),
		.i_restart      (i_restart),
		.i_decision_stb (decision_stb),
		.i_decision     (decision),
		.i_nt_done      (nt_done),
		.i_ccc_done     (ccc_done),
		.o_enthdr_en    (o_enthdr_en),
		.o_rx_en        (rx_en),
		.o_rx_mode      (rx_mode),
		.o_nt_en        (nt_en),
		.o_ccc_en       (ccc_en)
	);

	hdr_bit_counter bit_counter_i (
		.i_sys_clk   (i_sys_clk),
		.i_sys_rst   (i_sys_rst),
		.i_rx_en     (rx_en),
		.i_bit_stb   (i_bit_stb),
		.o_shift_stb (shift_stb),
		.o_last_bit  (last_bit)
	);

	hdr_rx_deser rx_deser_i (
		.i_sys_clk      (i_sys_clk),
		.i_sys_rst      (i_sys_rst),
		.i_shift_stb    (shift_stb),
		.i_last_bit     (last_bit),
		.i_bit          (i_bit),
		.i_rx_mode      (rx_mode),
		.i_own_addr     (o_own_addr),
		.o_word_stb     (word_stb),
		.o_word         (word),
		.o_parity_err   (word_par_err),
		.o_cmd_arg      (cmd_arg),
		.o_decision_stb (decision_stb),
		.o_decision     (decision)
	);

	hdr_nt_unit nt_unit_i (
		.i_sys_clk    (i_sys_clk),
		.i_sys_rst    (i_sys_rst),
		.i_nt_en      (nt_en),
		.i_word_stb   (word_stb),
		.i_word       (word),
		.i_parity_err (word_par_err),
		.i_cmd_arg    (cmd_arg),
		.o_wr_stb     (o_wr_stb),
		.o_wr_addr    (o_wr_addr),
		.o_wr_data    (o_wr_data),
		.o_nt_done    (nt_done),
		.o_bad_word   () // parity errors already leave through o_parity_err
	);

	hdr_ccc_unit ccc_unit_i (
		.i_sys_clk    (i_sys_clk),
		.i_sys_rst    (i_sys_rst),
		.i_ccc_en     (ccc_en),
		.i_word_stb   (word_stb),
		.i_word       (word),
		.i_parity_err (word_par_err),
		.i_cmd_arg    (cmd_arg),
		.o_own_addr   (o_own_addr),
		.o_ccc_done   (ccc_done)
	);

endmodule

`default_nettype wire

//--- tb/tb_hdr_target.sv
`timescale 1ns/100ps
`default_nettype none

`include "hdr_defs.svh"

module tb_hdr_target;

	localparam int TIMEOUT_CYCLES = 6000; // about 150 words of 34 cycles plus margin

	logic                      i_sys_clk;
	logic                      i_sys_rst;
	logic                      i_enthdr;
	logic                      i_exit;
	logic                      i_restart;
	logic                      i_bit_stb;
	logic                      i_bit;
	logic                      o_enthdr_en;
	logic                      o_wr_stb;
	logic [`HDR_REG_AW-1:0]    o_wr_addr;
	logic [`HDR_PAYLOAD_W-1:0] o_wr_data;
	logic                      o_parity_err;
	logic [`HDR_ADDR_W-1:0]    o_own_addr;

	logic [`HDR_PAYLOAD_W-1:0] model_regs [`HDR_REG_DEPTH];
	logic [`HDR_ADDR_W-1:0]    model_addr;
	logic [18:0]               exp_wr [$]; // {index, data} in write order
	logic [18:0]               head_wr;
	logic [`HDR_PAYLOAD_W-1:0] tx_data [`HDR_REG_DEPTH];
	logic                      tx_bad [`HDR_REG_DEPTH];
	logic [`HDR_ADDR_W-1:0]    old_addr;
	logic [`HDR_ADDR_W-1:0]    new_addr;
	int                        exp_parity_cnt;
	int                        parity_seen = 0;
	int                        cycle_cnt = 0;
	int                        n;
	int                        txn;
	string                     test_name;

	hdr_target_top dut_i (
		.i_sys_clk    (i_sys_clk),
		.i_sys_rst    (i_sys_rst),
		.i_enthdr     (i_enthdr),
		.i_exit       (i_exit),
		.i_restart    (i_restart),
		.i_bit_stb    (i_bit_stb),
		.i_bit        (i_bit),
		.o_enthdr_en  (o_enthdr_en),
		.o_wr_stb     (o_wr_stb),
		.o_wr_addr    (o_wr_addr),
		.o_wr_data    (o_wr_data),
		.o_parity_err (o_parity_err),
		.o_own_addr   (o_own_addr)
	);

	always #10 i_sys_clk = ~i_sys_clk;

	task automatic stop_run();
		$display("** FAIL **");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_write(input string name, input logic [`HDR_REG_AW-1:0] exp_idx,
			input logic [`HDR_PAYLOAD_W-1:0] exp_data, input logic [`HDR_REG_AW-1:0] act_idx,
			input logic [`HDR_PAYLOAD_W-1:0] act_data);
		if (exp_idx !== act_idx || exp_data !== act_data) begin
			$display("CHECK FAILED %s: expected write [%0d]=%h, actual write [%0d]=%h",
				name, exp_idx, exp_data, act_idx, act_data);
			stop_run();
		end
	endtask

	task automatic check_addr(input string name, input logic [`HDR_ADDR_W-1:0] exp_addr,
			input logic [`HDR_ADDR_W-1:0] act_addr);
		if (exp_addr !== act_addr) begin
			$display("CHECK FAILED %s: expected address %h, actual %h", name, exp_addr, act_addr);
			stop_run();
		end
	endtask

	task automatic check_count(input string name, input int exp_cnt, input int act_cnt);
		if (exp_cnt != act_cnt) begin
			$display("CHECK FAILED %s: expected %0d parity errors, actual %0d",
				name, exp_cnt, act_cnt);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic exp_flag, input logic act_flag);
		if (exp_flag !== act_flag) begin
			$display("CHECK FAILED %s: expected enthdr_en %b, actual %b", name, exp_flag, act_flag);
			stop_run();
		end
	endtask

	// payload followed by its even-parity bit, which can be spoiled on purpose
	function automatic logic [16:0] encode_word(input logic [15:0] payload, input logic flip);
		return {payload, (^payload) ^ flip};
	endfunction

	function automatic logic [15:0] make_cmd(input logic ccc, input logic [6:0] addr,
			input logic [7:0] arg);
		return {ccc, addr, arg};
	endfunction

	// expected effect of one command and the data words held in tx_data and tx_bad
	function automatic void predict_transaction(input logic [15:0] cmd, input logic cmd_bad);
		hdr_pkg::rx_decision_e dec;
		hdr_pkg::ccc_opcode_e  op;
		int                    count;
		int                    i;
		if (cmd_bad) begin
			dec = hdr_pkg::ERROR;
		end else if (cmd[15]) begin
			dec = hdr_pkg::CCC;
		end else if (cmd[14:8] == model_addr) begin
			dec = hdr_pkg::ME_DDR;
		end else begin
			dec = hdr_pkg::NOT_ME;
		end
		op    = hdr_pkg::ccc_opcode_e'(cmd[7:0]);
		count = int'(cmd[2:0]) + 1;
		case (dec)
			hdr_pkg::ERROR: exp_parity_cnt++;
			hdr_pkg::CCC: begin
				if (op == hdr_pkg::CCC_RSTADDR) begin
					model_addr = `HDR_DEFAULT_ADDR;
				end else if (op == hdr_pkg::CCC_SETADDR) begin
					if (tx_bad[0]) begin
						exp_parity_cnt++; // the address stays as it was
					end else begin
						model_addr = tx_data[0][`HDR_ADDR_W-1:0];
					end
				end
			end
			hdr_pkg::ME_DDR: begin
				for (i = 0; i < count; i++) begin
					if (tx_bad[i]) begin
						exp_parity_cnt++;
					end else begin
						model_regs[i] = tx_data[i];
						exp_wr.push_back({3'(i), model_regs[i]});
					end
				end
			end
			default: ; // not addressed, every later bit is ignored
		endcase
	endfunction

	task automatic idle(input int cycles);
		repeat (cycles) @(negedge i_sys_clk);
	endtask

	task automatic pulse_control(input logic enthdr, input logic exit_p, input logic restart);
		@(negedge i_sys_clk);
		i_enthdr  = enthdr;
		i_exit    = exit_p;
		i_restart = restart;
		@(negedge i_sys_clk);
		i_enthdr  = 1'b0;
		i_exit    = 1'b0;
		i_restart = 1'b0;
	endtask

	task automatic send_word(input logic [16:0] frame);
		int i;
		for (i = 16; i >= 0; i--) begin
			@(negedge i_sys_clk);
			i_bit_stb = 1'b1;
			i_bit     = frame[i]; // MSB first, parity last
			@(negedge i_sys_clk);
			i_bit_stb = 1'b0;
		end
	endtask

	task automatic fill_data(input int count);
		int i;
		for (i = 0; i < count; i++) begin
			tx_data[i] = 16'($urandom);
			tx_bad[i]  = 1'b0;
		end
	endtask

	task automatic run_transaction(input logic [15:0] cmd, input logic cmd_bad, input int words);
		int i;
		predict_transaction(cmd, cmd_bad);
		send_word(encode_word(cmd, cmd_bad));
		for (i = 0; i < words; i++) begin
			send_word(encode_word(tx_data[i], tx_bad[i]));
		end
		while (exp_wr.size() != 0) begin
			@(negedge i_sys_clk); // timeout process bounds this wait
		end
		idle(3);
	endtask

	task automatic wait_addr_change(input logic [`HDR_ADDR_W-1:0] prev);
		int waited;
		waited = 0;
		while (o_own_addr == prev && waited < 8) begin
			@(negedge i_sys_clk);
			waited++;
		end
	endtask

	// every write and parity pulse is checked against the model
	always @(negedge i_sys_clk) begin
		if (i_sys_rst) begin
			if (o_wr_stb) begin
				if (exp_wr.size() == 0) begin
					$display("%s: register %0d was written although no write was expected",
						test_name, o_wr_addr);
					stop_run();
				end else begin
					head_wr = exp_wr.pop_front();
					check_write(test_name, head_wr[18:16], head_wr[15:0], o_wr_addr, o_wr_data);
				end
			end
			if (o_parity_err) begin
				parity_seen++;
			end
		end
	end

	always @(posedge i_sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			stop_run();
		end
	end

	initial begin
		void'($urandom(32'hd0fa));
		i_sys_clk      = 1'b0;
		i_sys_rst      = 1'b0;
		i_enthdr       = 1'b0;
		i_exit         = 1'b0;
		i_restart      = 1'b0;
		i_bit_stb      = 1'b0;
		i_bit          = 1'b0;
		model_addr     = `HDR_DEFAULT_ADDR;
		exp_parity_cnt = 0;
		test_name      = "reset";
		repeat (3) @(negedge i_sys_clk);
		i_sys_rst = 1'b1;
		idle(1);
		check_flag(test_name, 1'b1, o_enthdr_en);
		check_addr(test_name, `HDR_DEFAULT_ADDR, o_own_addr);

		test_name = "addressed_write";
		for (txn = 0; txn < 3; txn++) begin
			n = $urandom_range(1, 8);
			fill_data(n);
			if (txn == 0) begin
				pulse_control(1'b1, 1'b0, 1'b0); // first transaction enters HDR from SDR
			end else begin
				pulse_control(1'b0, 1'b0, 1'b1);
			end
			run_transaction(make_cmd(1'b0, model_addr, 8'(n - 1)), 1'b0, n);
		end
		check_count(test_name, exp_parity_cnt, parity_seen);

		test_name = "not_me_and_cmd_parity";
		fill_data(2);
		pulse_control(1'b0, 1'b0, 1'b1);
		run_transaction(make_cmd(1'b0, model_addr ^ 7'($urandom_range(1, 127)), 8'd1), 1'b0, 2);
		pulse_control(1'b0, 1'b0, 1'b1);
		run_transaction(make_cmd(1'b0, model_addr, 8'd1), 1'b1, 2);
		check_count(test_name, exp_parity_cnt, parity_seen);
		n = $urandom_range(1, 8);
		fill_data(n);
		pulse_control(1'b0, 1'b0, 1'b1);
		run_transaction(make_cmd(1'b0, model_addr, 8'(n - 1)), 1'b0, n);

		test_name = "data_parity";
		fill_data(6);
		tx_bad[2] = 1'b1;
		pulse_control(1'b0, 1'b0, 1'b1);
		run_transaction(make_cmd(1'b0, model_addr, 8'd5), 1'b0, 6);
		check_count(test_name, exp_parity_cnt, parity_seen);

		test_name = "ccc_address";
		old_addr  = model_addr;
		new_addr  = 7'($urandom_range(1, 127));
		if (new_addr == old_addr) begin
			new_addr = new_addr ^ 7'h01;
		end
		fill_data(1);
		tx_data[0] = {9'd0, new_addr};
		pulse_control(1'b0, 1'b0, 1'b1);
		run_transaction(make_cmd(1'b1, 7'h7e, 8'(hdr_pkg::CCC_SETADDR)), 1'b0, 1);
		wait_addr_change(old_addr);
		check_addr(test_name, model_addr, o_own_addr);
		fill_data(2);
		pulse_control(1'b0, 1'b0, 1'b1);
		run_transaction(make_cmd(1'b0, old_addr, 8'd1), 1'b0, 2); // stale address, ignored
		pulse_control(1'b0, 1'b0, 1'b1);
		run_transaction(make_cmd(1'b0, model_addr, 8'd1), 1'b0, 2);
		pulse_control(1'b0, 1'b0, 1'b1);
		run_transaction(make_cmd(1'b1, 7'h7e, 8'(hdr_pkg::CCC_RSTADDR)), 1'b0, 0);
		wait_addr_change(new_addr);
		check_addr(test_name, 7'h2a, o_own_addr);
		check_count(test_name, exp_parity_cnt, parity_seen);

		test_name = "exit";
		pulse_control(1'b0, 1'b1, 1'b0);
		check_flag(test_name, 1'b1, o_enthdr_en);
		fill_data(2);
		send_word(encode_word(make_cmd(1'b0, model_addr, 8'd1), 1'b0)); // back in SDR, no effect
		send_word(encode_word(tx_data[0], 1'b0));
		send_word(encode_word(tx_data[1], 1'b1));
		idle(3);
		check_flag(test_name, 1'b1, o_enthdr_en);
		check_count(test_name, exp_parity_cnt, parity_seen);
		n = $urandom_range(1, 8);
		fill_data(n);
		pulse_control(1'b1, 1'b0, 1'b0);
		run_transaction(make_cmd(1'b0, model_addr, 8'(n - 1)), 1'b0, n);
		check_count(test_name, exp_parity_cnt, parity_seen);

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+rtl
rtl/hdr_pkg.sv
rtl/hdr_engine.sv
rtl/hdr_bit_counter.sv
rtl/hdr_rx_deser.sv
rtl/hdr_nt_unit.sv
rtl/hdr_ccc_unit.sv
rtl/hdr_target_top.sv
tb/tb_hdr_target.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the HDR-DDR target testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_hdr_target

output=$(./obj_dir/Vtb_hdr_target 2>&1) || true
echo "$output"

if echo "$output" | grep -qx '\*\* PASS \*\*'; then
	exit 0
fi
exit 1
